// File: source/cpuPkg.sv
package cpuPkg;

	localparam int xlen = 32;
	localparam int regAddrW = 5;

	// Major opcodes
	localparam logic [6:0] opOp     = 7'b0110011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opSystem = 7'b1110011;

	// ADDI x0, x0, 0
	localparam logic [31:0] nopWord = 32'h0000_0013;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluPassB
	} aluOp;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbLink
	} wbSel;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rFormat;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} iFormat;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sFormat;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} uFormat;

	// Scrambled J immediate
	typedef struct packed {
		logic imm20;
		logic [9:0] imm10to1;
		logic imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jFormat;

	typedef union packed {
		rFormat rType;
		iFormat iType;
		sFormat sType;
		uFormat uType;
		jFormat jType;
	} instrWord;

endpackage

// File: source/stageBus.sv
`timescale 1ns/1ps

interface idExBus
	import cpuPkg::*;
();
	logic [xlen-1:0] pc;
	logic [xlen-1:0] rs1Val;
	logic [xlen-1:0] rs2Val;
	logic [xlen-1:0] imm;
	logic [regAddrW-1:0] rd;
	cpuPkg::aluOp aluOp;
	logic aluSrcImm;
	logic memRead;
	logic memWrite;
	logic regWrite;
	cpuPkg::wbSel wbSel;
	logic isJump;
	logic halt;

	modport src (
		output pc, rs1Val, rs2Val, imm, rd, aluOp, aluSrcImm,
		output memRead, memWrite, regWrite, wbSel, isJump, halt
	);

	modport dst (
		input pc, rs1Val, rs2Val, imm, rd, aluOp, aluSrcImm,
		input memRead, memWrite, regWrite, wbSel, isJump, halt
	);
endinterface

interface exMemBus
	import cpuPkg::*;
();
	logic [xlen-1:0] aluResult;
	logic [xlen-1:0] storeData;
	logic [regAddrW-1:0] rd;
	logic memRead;
	logic memWrite;
	logic regWrite;
	cpuPkg::wbSel wbSel;
	logic [xlen-1:0] linkVal;
	logic halt;

	modport src (
		output aluResult, storeData, rd, memRead, memWrite, regWrite, wbSel, linkVal, halt
	);

	modport dst (
		input aluResult, storeData, rd, memRead, memWrite, regWrite, wbSel, linkVal, halt
	);
endinterface

// File: source/fetchStage.sv
`timescale 1ns/1ps

module fetchStage
	import cpuPkg::*;
(
	input logic CLK,
	input logic RSTn,
	input logic redirect,
	input logic [xlen-1:0] redirectPc,
	input logic haltSeen,
	input logic [xlen-1:0] iData,
	output logic [xlen-1:0] iAddr,
	output logic [xlen-1:0] ifPc,
	output instrWord ifInstr
);
	logic [xlen-1:0] pc;
	logic frozen;
	logic stall;

	assign stall = haltSeen || frozen;
	assign iAddr = pc;

	// Redirect wins over a halt that is being flushed
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= '0;
			frozen <= 1'b0;
		end else if (redirect) begin
			pc <= redirectPc;
		end else if (stall) begin
			frozen <= 1'b1;
		end else begin
			pc <= pc + xlen'(4);
		end
	end

	// IF/ID register
	always_ff @(posedge CLK) begin
		ifPc <= pc;
		if (RSTn || redirect || stall) begin
			ifInstr <= nopWord;
		end else begin
			ifInstr <= iData;
		end
	end

endmodule

// File: source/decodeStage.sv
`timescale 1ns/1ps

module decodeStage
	import cpuPkg::*;
(
	input logic CLK,
	input logic RSTn,
	input logic [xlen-1:0] ifPc,
	input instrWord ifInstr,
	input logic wbEn,
	input logic [regAddrW-1:0] wbAddr,
	input logic [xlen-1:0] wbData,
	output logic haltSeen,
	idExBus.src out
);
	logic [xlen-1:0] regs [32];
	logic [6:0] opcode;
	logic [regAddrW-1:0] rs1;
	logic [regAddrW-1:0] rs2;

	// Opcode and register fields sit at the same place in every format
	assign opcode = ifInstr.rType.opcode;
	assign rs1 = ifInstr.rType.rs1;
	assign rs2 = ifInstr.rType.rs2;

	// Only EBREAK is decoded from the system opcode
	assign haltSeen = (opcode == opSystem) && (ifInstr.iType.imm == 12'd1);

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEn && wbAddr != '0) begin
			regs[wbAddr] <= wbData;
		end
	end

	// Read ports see a write of the same cycle
	assign out.rs1Val = (rs1 == '0) ? '0 :
		(wbEn && wbAddr == rs1) ? wbData : regs[rs1];
	assign out.rs2Val = (rs2 == '0) ? '0 :
		(wbEn && wbAddr == rs2) ? wbData : regs[rs2];

	always_comb begin
		out.pc = ifPc;
		out.rd = ifInstr.rType.rd;
		out.imm = '0;
		out.aluOp = aluAdd;
		out.aluSrcImm = 1'b0;
		out.memRead = 1'b0;
		out.memWrite = 1'b0;
		out.regWrite = 1'b0;
		out.wbSel = wbAlu;
		out.isJump = 1'b0;
		out.halt = haltSeen;
		case (opcode)
			opOp: begin
				out.regWrite = 1'b1;
				case (ifInstr.rType.funct3)
					3'b000: out.aluOp = ifInstr.rType.funct7[5] ? aluSub : aluAdd;
					3'b010: out.aluOp = aluSlt;
					3'b100: out.aluOp = aluXor;
					3'b110: out.aluOp = aluOr;
					3'b111: out.aluOp = aluAnd;
					default: out.regWrite = 1'b0;
				endcase
			end
			opImm: begin
				out.imm = {{20{ifInstr.iType.imm[11]}}, ifInstr.iType.imm};
				out.aluSrcImm = 1'b1;
				// ADDI only
				out.regWrite = (ifInstr.iType.funct3 == 3'b000);
			end
			opLui: begin
				out.imm = {ifInstr.uType.imm, 12'b0};
				out.aluOp = aluPassB;
				out.aluSrcImm = 1'b1;
				out.regWrite = 1'b1;
			end
			opLoad: begin
				out.imm = {{20{ifInstr.iType.imm[11]}}, ifInstr.iType.imm};
				out.aluSrcImm = 1'b1;
				out.memRead = 1'b1;
				out.regWrite = 1'b1;
				out.wbSel = wbMem;
			end
			opStore: begin
				out.imm = {{20{ifInstr.sType.immHi[6]}}, ifInstr.sType.immHi,
					ifInstr.sType.immLo};
				out.aluSrcImm = 1'b1;
				out.memWrite = 1'b1;
			end
			opJal: begin
				out.imm = {{11{ifInstr.jType.imm20}}, ifInstr.jType.imm20,
					ifInstr.jType.imm19to12, ifInstr.jType.imm11,
					ifInstr.jType.imm10to1, 1'b0};
				out.isJump = 1'b1;
				out.regWrite = 1'b1;
				out.wbSel = wbLink;
			end
			default: begin
				out.regWrite = 1'b0;
			end
		endcase
	end

endmodule

// File: source/idExReg.sv
`timescale 1ns/1ps

module idExReg
	import cpuPkg::*;
(
	input logic CLK,
	input logic RSTn,
	input logic redirect,
	idExBus.dst in,
	idExBus.src out
);

	// Data fields
	always_ff @(posedge CLK) begin
		out.pc <= in.pc;
		out.rs1Val <= in.rs1Val;
		out.rs2Val <= in.rs2Val;
		out.imm <= in.imm;
		out.rd <= in.rd;
	end

	// A flushed slot leaves as a NOP
	always_ff @(posedge CLK) begin
		if (RSTn || redirect) begin
			out.aluOp <= aluAdd;
			out.aluSrcImm <= 1'b0;
			out.memRead <= 1'b0;
			out.memWrite <= 1'b0;
			out.regWrite <= 1'b0;
			out.wbSel <= wbAlu;
			out.isJump <= 1'b0;
			out.halt <= 1'b0;
		end else begin
			out.aluOp <= in.aluOp;
			out.aluSrcImm <= in.aluSrcImm;
			out.memRead <= in.memRead;
			out.memWrite <= in.memWrite;
			out.regWrite <= in.regWrite;
			out.wbSel <= in.wbSel;
			out.isJump <= in.isJump;
			out.halt <= in.halt;
		end
	end

endmodule

// File: source/executeStage.sv
`timescale 1ns/1ps

module executeStage
	import cpuPkg::*;
(
	input logic CLK,
	input logic RSTn,
	idExBus.dst in,
	output logic redirect,
	output logic [xlen-1:0] redirectPc,
	exMemBus.src out
);
	logic [xlen-1:0] opB;
	logic [xlen-1:0] aluRes;
	logic [xlen-1:0] linkVal;

	assign opB = in.aluSrcImm ? in.imm : in.rs2Val;

	always_comb begin
		case (in.aluOp)
			aluAdd: aluRes = in.rs1Val + opB;
			aluSub: aluRes = in.rs1Val - opB;
			aluAnd: aluRes = in.rs1Val & opB;
			aluOr: aluRes = in.rs1Val | opB;
			aluXor: aluRes = in.rs1Val ^ opB;
			aluSlt: aluRes = {{(xlen - 1){1'b0}}, $signed(in.rs1Val) < $signed(opB)};
			aluPassB: aluRes = opB;
			default: aluRes = '0;
		endcase
	end

	// JAL resolves here, so the two younger slots get flushed
	assign redirect = in.isJump;
	assign redirectPc = in.pc + in.imm;
	assign linkVal = in.pc + xlen'(4);

	// EX/MEM register
	always_ff @(posedge CLK) begin
		out.aluResult <= aluRes;
		out.storeData <= in.rs2Val;
		out.rd <= in.rd;
		out.linkVal <= linkVal;
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			out.memRead <= 1'b0;
			out.memWrite <= 1'b0;
			out.regWrite <= 1'b0;
			out.wbSel <= wbAlu;
			out.halt <= 1'b0;
		end else begin
			out.memRead <= in.memRead;
			out.memWrite <= in.memWrite;
			out.regWrite <= in.regWrite;
			out.wbSel <= in.wbSel;
			out.halt <= in.halt;
		end
	end

endmodule

// File: source/memWbStage.sv
`timescale 1ns/1ps

module memWbStage
	import cpuPkg::*;
(
	input logic CLK,
	input logic RSTn,
	exMemBus.dst in,
	input logic [xlen-1:0] dRData,
	output logic [xlen-1:0] dAddr,
	output logic [xlen-1:0] dWData,
	output logic dRead,
	output logic dWrite,
	output logic wbEn,
	output logic [regAddrW-1:0] wbAddr,
	output logic [xlen-1:0] wbData,
	output logic halted
);
	logic haltReg;

	// Word access only
	assign dAddr = in.aluResult;
	assign dWData = in.storeData;
	assign dRead = in.memRead;
	assign dWrite = in.memWrite;

	assign wbEn = in.regWrite && (in.rd != '0);
	assign wbAddr = in.rd;

	always_comb begin
		case (in.wbSel)
			wbMem: wbData = dRData;
			wbLink: wbData = in.linkVal;
			default: wbData = in.aluResult;
		endcase
	end

	// Sticky until reset
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			haltReg <= 1'b0;
		end else if (in.halt) begin
			haltReg <= 1'b1;
		end
	end

	assign halted = haltReg || in.halt;

endmodule

// File: source/riscCore.sv
`timescale 1ns/1ps

module riscCore
	import cpuPkg::*;
(
	input logic CLK,
	input logic RSTn,
	input logic [xlen-1:0] iData,
	input logic [xlen-1:0] dRData,
	output logic [xlen-1:0] iAddr,
	output logic [xlen-1:0] dAddr,
	output logic [xlen-1:0] dWData,
	output logic dRead,
	output logic dWrite,
	output logic halted
);
	logic [xlen-1:0] ifPc;
	instrWord ifInstr;
	logic haltSeen;
	logic redirect;
	logic [xlen-1:0] redirectPc;
	logic wbEn;
	logic [regAddrW-1:0] wbAddr;
	logic [xlen-1:0] wbData;

	idExBus idBus ();
	idExBus exBus ();
	exMemBus memBus ();

	fetchStage fetch (
		.CLK(CLK), .RSTn(RSTn), .redirect(redirect), .redirectPc(redirectPc),
		.haltSeen(haltSeen), .iData(iData), .iAddr(iAddr),
		.ifPc(ifPc), .ifInstr(ifInstr)
	);

	decodeStage decode (
		.CLK(CLK), .RSTn(RSTn), .ifPc(ifPc), .ifInstr(ifInstr),
		.wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
		.haltSeen(haltSeen), .out(idBus.src)
	);

	idExReg idEx (
		.CLK(CLK), .RSTn(RSTn), .redirect(redirect),
		.in(idBus.dst), .out(exBus.src)
	);

	executeStage execute (
		.CLK(CLK), .RSTn(RSTn), .in(exBus.dst),
		.redirect(redirect), .redirectPc(redirectPc), .out(memBus.src)
	);

	memWbStage memWb (
		.CLK(CLK), .RSTn(RSTn), .in(memBus.dst), .dRData(dRData),
		.dAddr(dAddr), .dWData(dWData), .dRead(dRead), .dWrite(dWrite),
		.wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData), .halted(halted)
	);

endmodule

// File: test/riscProgram.svh
function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

// SW with x0 as base
function automatic logic [31:0] encSw(logic [4:0] rs2, logic [11:0] off);
	return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
endfunction

task automatic emit(logic [31:0] word);
	imem[progLen] = word;
	progLen++;
endtask

// One NOP so that the next instruction can use the result
task automatic emitSpaced(logic [31:0] word);
	emit(word);
	emit(32'h0000_0013);
endtask

task automatic expectStore(logic [4:0] rs, logic [31:0] value, string name);
	emitSpaced(encSw(rs, 12'(expAddr.size() * 4)));
	expAddr.push_back(32'(expAddr.size() * 4));
	expData.push_back(value);
	expName.push_back(name);
endtask

// x3 = rs1 op rs2, then store x3
task automatic aluCheck(string name, logic [6:0] f7, logic [2:0] f3,
		logic [4:0] rs1, logic [4:0] rs2, logic [31:0] value);
	emitSpaced({f7, rs2, rs1, f3, 5'd3, 7'b0110011});
	expectStore(5'd3, value, name);
endtask

task automatic loadConst(logic [4:0] rd, logic [31:0] value);
	logic [31:0] hi;
	// ADDI sign-extends, so round the upper part
	hi = value + 32'h800;
	emitSpaced({hi[31:12], rd, 7'b0110111});
	emitSpaced(encI(value[11:0], rd, 3'b000, rd, 7'b0010011));
endtask

task automatic buildProgram();
	logic [31:0] a;
	logic [31:0] b;
	logic [11:0] imm;
	logic [19:0] upper;
	a = nextRandom();
	b = nextRandom();
	imm = 12'(nextRandom());
	upper = 20'(nextRandom());
	progLen = 0;
	loadConst(5'd1, a);
	loadConst(5'd2, b);
	aluCheck("ADD", 7'h00, 3'b000, 5'd1, 5'd2, a + b);
	aluCheck("SUB", 7'h20, 3'b000, 5'd1, 5'd2, a - b);
	aluCheck("AND", 7'h00, 3'b111, 5'd1, 5'd2, a & b);
	aluCheck("OR", 7'h00, 3'b110, 5'd1, 5'd2, a | b);
	aluCheck("XOR", 7'h00, 3'b100, 5'd1, 5'd2, a ^ b);
	aluCheck("SLT", 7'h00, 3'b010, 5'd1, 5'd2, {31'd0, $signed(a) < $signed(b)});
	aluCheck("SLT reversed", 7'h00, 3'b010, 5'd2, 5'd1, {31'd0, $signed(b) < $signed(a)});
	emitSpaced(encI(imm, 5'd1, 3'b000, 5'd3, 7'b0010011));
	expectStore(5'd3, a + {{20{imm[11]}}, imm}, "ADDI");
	emitSpaced({upper, 5'd3, 7'b0110111});
	expectStore(5'd3, {upper, 12'd0}, "LUI");
	// Store, load back into x4, store again
	loadAddr = 32'(expAddr.size() * 4);
	expectStore(5'd1, a, "SW");
	emitSpaced(encI(loadAddr[11:0], 5'd0, 3'b010, 5'd4, 7'b0000011));
	expectStore(5'd4, a, "LW round trip");
	// JAL x5 with offset 16 skips three stores
	jalAt = 32'(progLen * 4);
	jalTarget = jalAt + 32'd16;
	emit({1'b0, 10'd8, 1'b0, 8'd0, 5'd5, 7'b1101111});
	emit(encSw(5'd1, skipAddr[11:0]));
	emit(encSw(5'd2, skipAddr[11:0]));
	emit(encSw(5'd3, skipAddr[11:0]));
	expectStore(5'd5, jalAt + 32'd4, "JAL link");
	emitSpaced(encI(12'h155, 5'd0, 3'b000, 5'd0, 7'b0010011));
	expectStore(5'd0, 32'd0, "x0");
	// EBREAK, then a store that is fetched but never runs
	emit(32'h0010_0073);
	emit(encSw(5'd1, skipAddr[11:0]));
endtask

// File: test/riscCoreTb.sv
`timescale 1ns/1ps

module riscCoreTb;
	localparam int resetCycles = 5;
	localparam logic [31:0] skipAddr = 32'h0000_00FC;

	logic CLK;
	logic RSTn;
	logic [31:0] iData;
	logic [31:0] dRData;
	logic [31:0] iAddr;
	logic [31:0] dAddr;
	logic [31:0] dWData;
	logic dRead;
	logic dWrite;
	logic halted;

	logic [31:0] imem [256];
	logic [31:0] dmem [64];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	string expName [$];
	logic [31:0] loadAddr;
	logic [31:0] jalAt;
	logic [31:0] jalTarget;
	logic [31:0] rngState;
	logic [31:0] prevIAddr = 32'd0;
	logic prevHalted = 1'b0;
	int progLen;
	int storeIdx = 0;
	int cycle = 0;
	int errors = 0;
	int limit;

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	`include "riscProgram.svh"

	riscCore UUT (
		.CLK(CLK), .RSTn(RSTn), .iData(iData), .dRData(dRData),
		.iAddr(iAddr), .dAddr(dAddr), .dWData(dWData),
		.dRead(dRead), .dWrite(dWrite), .halted(halted)
	);

	// Both memories read combinationally
	assign iData = imem[iAddr[9:2]];
	// Load data only shows up while dRead is high
	assign dRData = dRead ? dmem[dAddr[7:2]] : 32'd0;

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycle <= cycle + 1;
		prevIAddr <= iAddr;
		prevHalted <= halted;
		if (!RSTn && dWrite) begin
			dmem[dAddr[7:2]] <= dWData;
			storeIdx <= storeIdx + 1;
		end
	end

	resetIdle: assert property (@(posedge CLK) (cycle >= 1 && cycle <= resetCycles)
			|-> (iAddr == 32'd0 && !dRead && !dWrite && !halted))
		else begin
			errors++;
			$display("Error reset: expected iAddr 0 and controls 000, actual %h and %b%b%b",
				$sampled(iAddr), $sampled(dRead), $sampled(dWrite), $sampled(halted));
		end

	storeCount: assert property (@(posedge CLK) (!RSTn && dWrite)
			|-> storeIdx < expAddr.size())
		else begin
			errors++;
			$display("Unexpected extra store of %h to %h", $sampled(dWData), $sampled(dAddr));
		end

	storeValue: assert property (@(posedge CLK) (!RSTn && dWrite && storeIdx < expAddr.size())
			|-> (dAddr == expAddr[storeIdx] && dWData == expData[storeIdx]))
		else begin
			errors++;
			$display("Error %s: expected %h at %h, actual %h at %h",
				expName[$sampled(storeIdx)], expData[$sampled(storeIdx)],
				expAddr[$sampled(storeIdx)], $sampled(dWData), $sampled(dAddr));
		end

	// Flushed slots and the word after EBREAK all target skipAddr
	noSkipped: assert property (@(posedge CLK) (!RSTn && dWrite) |-> dAddr != skipAddr)
		else begin
			errors++;
			$display("A store that should have been flushed reached memory");
		end

	loadAddress: assert property (@(posedge CLK) (!RSTn && dRead) |-> dAddr == loadAddr)
		else begin
			errors++;
			$display("Error load: expected dAddr %h, actual %h", loadAddr, $sampled(dAddr));
		end

	jalFetch: assert property (@(posedge CLK) (!RSTn && prevIAddr == jalAt + 32'd8)
			|-> iAddr == jalTarget)
		else begin
			errors++;
			$display("Error JAL target: expected iAddr %h, actual %h", jalTarget,
				$sampled(iAddr));
		end

	haltHold: assert property (@(posedge CLK) (!RSTn && prevHalted)
			|-> (halted && !dWrite && iAddr == prevIAddr))
		else begin
			errors++;
			$display("Core left the halted state: halted %b dWrite %b iAddr %h, was %h",
				$sampled(halted), $sampled(dWrite), $sampled(iAddr), $sampled(prevIAddr));
		end

	haltStores: assert property (@(posedge CLK) (!RSTn && halted)
			|-> storeIdx == expAddr.size())
		else begin
			errors++;
			$display("Error halt: expected %0d stores, actual %0d", expAddr.size(),
				$sampled(storeIdx));
		end

	initial begin
		RSTn = 1'b1;
		rngState = 32'd95;
		buildProgram();
		for (int i = 0; i < 64; i++) begin
			dmem[i] <= 32'hDA7A_0000 + 32'(i * 4);
		end
		limit = resetCycles + progLen + 50;
		repeat (resetCycles) @(posedge CLK);
		#1 RSTn = 1'b0;
		while (!halted && cycle < limit) begin
			@(posedge CLK);
			#1;
		end
		if (!halted) begin
			errors++;
			$display("Timeout: the core did not halt within %0d cycles", limit);
		end else begin
			// A few more cycles for the post-halt checks
			repeat (4) @(posedge CLK);
			#1;
		end
		$display("Summary: %0d errors, %0d of %0d stores seen",
			errors, storeIdx, expAddr.size());
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: riscCore.f
+incdir+test
source/cpuPkg.sv
source/stageBus.sv
source/fetchStage.sv
source/decodeStage.sv
source/idExReg.sv
source/executeStage.sv
source/memWbStage.sv
source/riscCore.sv
test/riscCoreTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f riscCore.f --top-module riscCoreTb -o simRiscCore
./obj_dir/simRiscCore | tee sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
